// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

  ////////////////////
  // operations
  ////////////////////

  // csr instruction op, applied at next edge
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////
  // address map
  ////////////////////

  // page view, 32 addresses per page
  typedef struct packed {
    logic [6:0] page;
    logic [4:0] idx;
  } csr_addr_split_t;

  // same 12 bits, flat or page/index
  typedef union packed {
    logic [11:0]     flat;
    csr_addr_split_t split;
  } csr_addr_u;

  localparam logic [11:0] CSR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_MEPC     = 12'h341;
  localparam logic [11:0] CSR_MCAUSE   = 12'h342;
  localparam logic [11:0] CSR_PCER     = 12'h7A0;
  localparam logic [11:0] CSR_PCMR     = 12'h7A1;
  localparam logic [11:0] CSR_PCCR_ALL = 12'h79F;

  // 0x780 >> 5, counter page
  localparam logic [6:0] CSR_PCCR_PAGE = 7'h3C;

  // mstatus fields
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;
  // mpp = 2'b11, machine mode only
  localparam logic [31:0] MSTATUS_RESET_WORD = 32'(2'b11) << MSTATUS_MPP_LSB;

  ////////////////////
  // internal buses
  ////////////////////

  // one-hot target selects from the decoder
  typedef struct packed {
    logic       mstatus;
    logic       mepc;
    logic       mcause;
    logic       pcer;
    logic       pcmr;
    logic       pccr;
    logic       pccr_all;
    logic [4:0] pccr_idx;
  } csr_sel_t;

  // resolved write, already merged for set/clear
  typedef struct packed {
    logic        we;
    logic [31:0] data;
  } csr_wr_t;

  // controller requests for trap entry and return
  typedef struct packed {
    logic        save_cause;
    logic        save_if;
    logic        save_id;
    logic        restore_mret;
    logic [5:0]  cause;
    logic [31:0] pc_if;
    logic [31:0] pc_id;
  } trap_req_t;

endpackage

`default_nettype wire

// ==== perf_pkg.sv ====
`default_nettype none

package perf_pkg;

  localparam int N_PERF_COUNTERS = 11;

  // counter index per event class
  localparam int PERF_CYCLES     = 0;
  localparam int PERF_INSTR      = 1;
  localparam int PERF_LD_STALL   = 2;
  localparam int PERF_JR_STALL   = 3;
  localparam int PERF_IMISS      = 4;
  localparam int PERF_LD         = 5;
  localparam int PERF_ST         = 6;
  localparam int PERF_JUMP       = 7;
  localparam int PERF_BRANCH     = 8;
  localparam int PERF_BTAKEN     = 9;
  localparam int PERF_COMPRESSED = 10;

  // pcmr bits, global enable and saturation
  localparam int PCMR_EN_BIT  = 0;
  localparam int PCMR_SAT_BIT = 1;
  localparam logic [1:0] PCMR_RESET = 2'b11;

  // raw event strobes from the core
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic mem_load;
    logic mem_store;
  } perf_events_t;

endpackage

`default_nettype wire

// ==== csr_access.sv ====
`default_nettype none

module csr_access
  import csr_pkg::*;
(
  input  wire logic        csr_access_i,
  input  csr_addr_u        csr_addr_i,
  input  csr_op_e          csr_op_i,
  input  wire logic [31:0] csr_wdata_i,
  // read words back from the targets
  input  wire logic [31:0] trap_rdata_i,
  input  wire logic [31:0] perf_rdata_i,

  output csr_sel_t         sel_o,
  output csr_wr_t          wr_o,
  output logic [31:0]      csr_rdata_o
);

  logic trap_hit;
  logic perf_hit;

  ////////////////////
  // address decode
  ////////////////////

  always_comb begin
    sel_o = '0;

    // fixed addresses, flat view
    case (csr_addr_i.flat)
      CSR_MSTATUS:  sel_o.mstatus  = 1'b1;
      CSR_MEPC:     sel_o.mepc     = 1'b1;
      CSR_MCAUSE:   sel_o.mcause   = 1'b1;
      CSR_PCER:     sel_o.pcer     = 1'b1;
      CSR_PCMR:     sel_o.pcmr     = 1'b1;
      CSR_PCCR_ALL: sel_o.pccr_all = 1'b1;
      default: ;
    endcase

    // 0x780..0x79e by page, top slot is write-all
    if (csr_addr_i.split.page == CSR_PCCR_PAGE && csr_addr_i.flat != CSR_PCCR_ALL) begin
      sel_o.pccr = 1'b1;
    end
    sel_o.pccr_idx = csr_addr_i.split.idx;
  end

  ////////////////////
  // read mux
  ////////////////////

  assign trap_hit = sel_o.mstatus | sel_o.mepc | sel_o.mcause;
  // write-all reads as zero, so not a perf hit
  assign perf_hit = sel_o.pcer | sel_o.pcmr | sel_o.pccr;

  always_comb begin
    if (trap_hit) begin
      csr_rdata_o = trap_rdata_i;
    end else if (perf_hit) begin
      csr_rdata_o = perf_rdata_i;
    end else begin
      // unmapped
      csr_rdata_o = '0;
    end
  end

  ////////////////////
  // write resolve
  ////////////////////

  always_comb begin
    wr_o.we = csr_access_i && (csr_op_i != CSR_OP_NONE);

    // set/clear merge against the current read word
    case (csr_op_i)
      CSR_OP_SET:   wr_o.data = csr_wdata_i | csr_rdata_o;
      CSR_OP_CLEAR: wr_o.data = ~csr_wdata_i & csr_rdata_o;
      default:      wr_o.data = csr_wdata_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== trap_ctrl.sv ====
`default_nettype none

module trap_ctrl
  import csr_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,

  input  csr_sel_t         sel_i,
  input  csr_wr_t          wr_i,
  input  trap_req_t        trap_i,

  output logic [31:0]      rdata_o,
  output logic [31:0]      epc_o,
  output logic             m_irq_enable_o
);

  // only the two mstatus enable bits are state
  logic        mie_q, mie_n;
  logic        mpie_q, mpie_n;
  logic [31:0] mepc_q, mepc_n;
  // mcause kept as irq flag plus 5 bit code
  logic        irq_q, irq_n;
  logic [4:0]  code_q, code_n;
  logic [31:0] exc_pc;

  ////////////////////
  // next state
  ////////////////////

  // trap pc comes from id unless save_if is set
  assign exc_pc = trap_i.save_if ? trap_i.pc_if : trap_i.pc_id;

  always_comb begin
    mie_n  = mie_q;
    mpie_n = mpie_q;
    mepc_n = mepc_q;
    irq_n  = irq_q;
    code_n = code_q;

    // software writes have lowest priority
    if (wr_i.we) begin
      if (sel_i.mstatus) begin
        mie_n  = wr_i.data[MSTATUS_MIE_BIT];
        mpie_n = wr_i.data[MSTATUS_MPIE_BIT];
      end
      if (sel_i.mepc) begin
        mepc_n = wr_i.data;
      end
      if (sel_i.mcause) begin
        irq_n  = wr_i.data[31];
        code_n = wr_i.data[4:0];
      end
    end

    // trap entry beats mret
    if (trap_i.save_cause) begin
      mpie_n = mie_q;
      mie_n  = 1'b0;
      mepc_n = exc_pc;
      irq_n  = trap_i.cause[5];
      code_n = trap_i.cause[4:0];
    end else if (trap_i.restore_mret) begin
      mie_n  = mpie_q;
      mpie_n = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q  <= 1'b0;
      mpie_q <= 1'b0;
      mepc_q <= '0;
      irq_q  <= 1'b0;
      code_q <= '0;
    end else begin
      mie_q  <= mie_n;
      mpie_q <= mpie_n;
      mepc_q <= mepc_n;
      irq_q  <= irq_n;
      code_q <= code_n;
    end
  end

  ////////////////////
  // read back
  ////////////////////

  always_comb begin
    rdata_o = '0;
    if (sel_i.mstatus) begin
      // mpp always reads machine mode
      rdata_o                   = MSTATUS_RESET_WORD;
      rdata_o[MSTATUS_MIE_BIT]  = mie_q;
      rdata_o[MSTATUS_MPIE_BIT] = mpie_q;
    end else if (sel_i.mepc) begin
      rdata_o = mepc_q;
    end else if (sel_i.mcause) begin
      rdata_o = {irq_q, 26'b0, code_q};
    end
  end

  // return pc and irq enable straight out
  assign epc_o          = mepc_q;
  assign m_irq_enable_o = mie_q;

endmodule

`default_nettype wire

// ==== perf_event_stage.sv ====
`default_nettype none

module perf_event_stage
  import perf_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,

  input  perf_events_t                    events_i,
  input  wire logic [N_PERF_COUNTERS-1:0] pcer_i,
  input  wire logic [1:0]                 pcmr_i,

  output logic [N_PERF_COUNTERS-1:0]      inc_o
);

  logic                       id_valid_q;
  logic [N_PERF_COUNTERS-1:0] cond;
  logic [N_PERF_COUNTERS-1:0] inc_q;

  // event conditions, stall/jump/branch need last cycle's id_valid
  assign cond[PERF_CYCLES]     = 1'b1;
  assign cond[PERF_INSTR]      = events_i.id_valid & events_i.is_decoding;
  assign cond[PERF_LD_STALL]   = events_i.ld_stall & id_valid_q;
  assign cond[PERF_JR_STALL]   = events_i.jr_stall & id_valid_q;
  // fetch wait, not counting redirects
  assign cond[PERF_IMISS]      = events_i.imiss & ~events_i.pc_set;
  assign cond[PERF_LD]         = events_i.mem_load;
  assign cond[PERF_ST]         = events_i.mem_store;
  assign cond[PERF_JUMP]       = events_i.jump & id_valid_q;
  assign cond[PERF_BRANCH]     = events_i.branch & id_valid_q;
  assign cond[PERF_BTAKEN]     = events_i.branch & events_i.branch_taken & id_valid_q;
  assign cond[PERF_COMPRESSED] = events_i.id_valid & events_i.is_decoding
                                 & events_i.is_compressed;

  // gate by pcer and global enable, then register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
    end else begin
      id_valid_q <= events_i.id_valid;
      inc_q      <= cond & pcer_i & {N_PERF_COUNTERS{pcmr_i[PCMR_EN_BIT]}};
    end
  end

  assign inc_o = inc_q;

endmodule

`default_nettype wire

// ==== perf_counter_bank.sv ====
`default_nettype none

module perf_counter_bank
  import csr_pkg::*;
  import perf_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,

  input  csr_sel_t                        sel_i,
  input  csr_wr_t                         wr_i,
  input  wire logic [N_PERF_COUNTERS-1:0] inc_i,

  output logic [N_PERF_COUNTERS-1:0]      pcer_o,
  output logic [1:0]                      pcmr_o,
  output logic [31:0]                     rdata_o
);

  logic [N_PERF_COUNTERS-1:0][31:0] cnt_q;
  logic [N_PERF_COUNTERS-1:0]       pcer_q;
  logic [1:0]                       pcmr_q;
  logic [N_PERF_COUNTERS-1:0]       cnt_we;

  ////////////////////
  // counters
  ////////////////////

  // per counter write strobe, single index or write-all
  always_comb begin
    for (int i = 0; i < N_PERF_COUNTERS; i++) begin
      cnt_we[i] = wr_i.we && (sel_i.pccr_all || (sel_i.pccr && sel_i.pccr_idx == 5'(i)));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < N_PERF_COUNTERS; i++) begin
        // write wins over a same-cycle increment
        if (cnt_we[i]) begin
          cnt_q[i] <= wr_i.data;
        end else if (inc_i[i] && !(pcmr_q[PCMR_SAT_BIT] && cnt_q[i] == '1)) begin
          cnt_q[i] <= cnt_q[i] + 32'd1;
        end
      end
    end
  end

  ////////////////////
  // pcer / pcmr
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= PCMR_RESET;
    end else begin
      if (wr_i.we && sel_i.pcer) begin
        pcer_q <= wr_i.data[N_PERF_COUNTERS-1:0];
      end
      if (wr_i.we && sel_i.pcmr) begin
        pcmr_q <= wr_i.data[1:0];
      end
    end
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;

  // read word, index 11 and up stays zero
  always_comb begin
    rdata_o = '0;
    if (sel_i.pcer) begin
      rdata_o[N_PERF_COUNTERS-1:0] = pcer_q;
    end else if (sel_i.pcmr) begin
      rdata_o[1:0] = pcmr_q;
    end else if (sel_i.pccr) begin
      for (int i = 0; i < N_PERF_COUNTERS; i++) begin
        if (sel_i.pccr_idx == 5'(i)) begin
          rdata_o = cnt_q[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== csr_unit.sv ====
`default_nettype none

module csr_unit
  import csr_pkg::*;
  import perf_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,

  // csr port from the pipeline
  input  wire logic        csr_access_i,
  input  csr_addr_u        csr_addr_i,
  input  csr_op_e          csr_op_i,
  input  wire logic [31:0] csr_wdata_i,
  output logic [31:0]      csr_rdata_o,

  // trap control from the controller
  input  trap_req_t        trap_i,
  output logic [31:0]      epc_o,
  output logic             m_irq_enable_o,

  // raw core events
  input  perf_events_t     events_i
);

  csr_sel_t                   sel;
  csr_wr_t                    wr;
  logic [31:0]                trap_rdata;
  logic [31:0]                perf_rdata;
  logic [N_PERF_COUNTERS-1:0] perf_inc;
  logic [N_PERF_COUNTERS-1:0] pcer;
  logic [1:0]                 pcmr;

  // decode, read mux and write merge
  csr_access u_csr_access (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .trap_rdata_i (trap_rdata),
    .perf_rdata_i (perf_rdata),
    .sel_o        (sel),
    .wr_o         (wr),
    .csr_rdata_o  (csr_rdata_o)
  );

  trap_ctrl u_trap_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .sel_i          (sel),
    .wr_i           (wr),
    .trap_i         (trap_i),
    .rdata_o        (trap_rdata),
    .epc_o          (epc_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  // event qualify stage, one cycle ahead of the bank
  perf_event_stage u_perf_event_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .events_i (events_i),
    .pcer_i   (pcer),
    .pcmr_i   (pcmr),
    .inc_o    (perf_inc)
  );

  perf_counter_bank u_perf_counter_bank (
    .clk     (clk),
    .rst_n   (rst_n),
    .sel_i   (sel),
    .wr_i    (wr),
    .inc_i   (perf_inc),
    .pcer_o  (pcer),
    .pcmr_o  (pcmr),
    .rdata_o (perf_rdata)
  );

endmodule

`default_nettype wire

// ==== csr_unit_asserts.sv ====
`default_nettype none

module csr_unit_asserts
  import csr_pkg::*;
  import perf_pkg::*;
(
  input wire logic                             clk,
  input wire logic                             rst_n,
  input wire trap_req_t                        trap_i,
  input wire logic                             m_irq_enable_o,
  input wire logic                             csr_access_i,
  input wire csr_sel_t                         sel,
  input wire csr_wr_t                          wr,
  input wire logic [31:0]                      csr_rdata_o,
  input wire logic [1:0]                       pcmr,
  input wire logic [N_PERF_COUNTERS-1:0][31:0] cnt
);

  // trap entry leaves interrupts off
  a_save_clears_mie: assert property (@(posedge clk) disable iff (!rst_n)
    trap_i.save_cause |=> !m_irq_enable_o)
    else $error("mie still set one cycle after trap save");

  // enable output matches mstatus.mie as read back
  a_mie_readback: assert property (@(posedge clk) disable iff (!rst_n)
    (csr_access_i && sel.mstatus) |-> csr_rdata_o[MSTATUS_MIE_BIT] == m_irq_enable_o)
    else $error("m_irq_enable_o differs from mstatus.mie");

  // disabled for a cycle, then no write, so nothing in flight can land
  a_counters_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!pcmr[PCMR_EN_BIT] ##1 !wr.we) |=> $stable(cnt))
    else $error("counter changed with global enable off");

endmodule

bind csr_unit csr_unit_asserts u_csr_unit_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .trap_i         (trap_i),
  .m_irq_enable_o (m_irq_enable_o),
  .csr_access_i   (csr_access_i),
  .sel            (sel),
  .wr             (wr),
  .csr_rdata_o    (csr_rdata_o),
  .pcmr           (pcmr),
  .cnt            (u_perf_counter_bank.cnt_q)
);

`default_nettype wire

// ==== tb_csr_unit.sv ====
`default_nettype none

module tb_csr_unit
  import csr_pkg::*;
  import perf_pkg::*;
();

  // reset, ops, trap, counting, saturation, enable/write-all
  localparam int TEST_CYCLES = 10 + 80 + 30 + 230 + 100 + 50;
  localparam int MAX_CYCLES  = 4 * TEST_CYCLES;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         csr_access_i;
  csr_addr_u    csr_addr_i;
  csr_op_e      csr_op_i;
  logic [31:0]  csr_wdata_i;
  logic [31:0]  csr_rdata_o;
  trap_req_t    trap_i;
  logic [31:0]  epc_o;
  logic         m_irq_enable_o;
  perf_events_t events_i;

  // reference model
  logic                       m_mie, m_mpie, m_irq;
  logic [4:0]                 m_code;
  logic [31:0]                m_mepc;
  logic [N_PERF_COUNTERS-1:0] m_pcer;
  logic [1:0]                 m_pcmr;
  logic [31:0]                m_cnt [N_PERF_COUNTERS];
  // qualified events waiting one cycle, as in the counter pipeline
  logic [N_PERF_COUNTERS-1:0] m_inc;
  logic                       m_idv_q;

  // expected outputs handed to the compare process
  logic        exp_valid = 1'b0;
  logic        chk_on    = 1'b0;
  logic [31:0] exp_rdata;
  logic [31:0] exp_epc;
  logic        exp_mie;

  string       test_name;
  int          errors = 0;
  int          err_mark;
  int          n_pass = 0;
  int          n_fail = 0;
  int          cycle_count = 0;
  logic [31:0] lcg_state;

  csr_unit u_csr_unit (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_access_i   (csr_access_i),
    .csr_addr_i     (csr_addr_i),
    .csr_op_i       (csr_op_i),
    .csr_wdata_i    (csr_wdata_i),
    .csr_rdata_o    (csr_rdata_o),
    .trap_i         (trap_i),
    .epc_o          (epc_o),
    .m_irq_enable_o (m_irq_enable_o),
    .events_i       (events_i)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  ////////////////////
  // model helpers
  ////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic perf_events_t rand_events();
    logic [31:0] r;
    r = next_rand();
    // low lcg bits repeat too soon so take upper bits
    return perf_events_t'(r[27:16]);
  endfunction

  // expected read word for an address
  function automatic logic [31:0] ref_rdata(input logic [11:0] addr);
    logic [31:0] rd;
    rd = 32'h0;
    case (addr)
      CSR_MSTATUS: rd = 32'h1800 | (32'(m_mie) << 3) | (32'(m_mpie) << 7);
      CSR_MEPC:    rd = m_mepc;
      CSR_MCAUSE:  rd = {m_irq, 26'h0, m_code};
      CSR_PCER:    rd = 32'(m_pcer);
      CSR_PCMR:    rd = 32'(m_pcmr);
      default: begin
        // counter page where 0x79f itself reads zero
        if (addr[11:5] == 7'h3C && addr != CSR_PCCR_ALL) begin
          for (int i = 0; i < N_PERF_COUNTERS; i++) begin
            if (addr[4:0] == 5'(i)) rd = m_cnt[i];
          end
        end
      end
    endcase
    return rd;
  endfunction

  // which counters an event word feeds
  function automatic logic [N_PERF_COUNTERS-1:0] event_hits(input perf_events_t ev,
                                                            input logic idv_prev);
    logic [N_PERF_COUNTERS-1:0] h;
    h                  = '0;
    h[PERF_CYCLES]     = 1'b1;
    h[PERF_INSTR]      = ev.id_valid && ev.is_decoding;
    h[PERF_LD_STALL]   = ev.ld_stall && idv_prev;
    h[PERF_JR_STALL]   = ev.jr_stall && idv_prev;
    h[PERF_IMISS]      = ev.imiss && !ev.pc_set;
    h[PERF_LD]         = ev.mem_load;
    h[PERF_ST]         = ev.mem_store;
    h[PERF_JUMP]       = ev.jump && idv_prev;
    h[PERF_BRANCH]     = ev.branch && idv_prev;
    h[PERF_BTAKEN]     = ev.branch && ev.branch_taken && idv_prev;
    h[PERF_COMPRESSED] = ev.id_valid && ev.is_decoding && ev.is_compressed;
    return h;
  endfunction

  ////////////////////
  // drive one cycle
  ////////////////////

  task automatic drive_cycle(input logic acc, input logic [11:0] addr, input csr_op_e op,
                             input logic [31:0] wdata, input trap_req_t tr,
                             input perf_events_t ev);
    logic [31:0] rd;
    logic [31:0] wword;
    logic        we;
    logic        old_mie;
    logic        old_mpie;
    @(negedge clk);
    csr_access_i    = acc;
    csr_addr_i.flat = addr;
    csr_op_i        = op;
    csr_wdata_i     = wdata;
    trap_i          = tr;
    events_i        = ev;
    // outputs seen in this cycle come from state before the edge
    rd        = ref_rdata(addr);
    exp_rdata = rd;
    exp_valid = acc;
    exp_epc   = m_mepc;
    exp_mie   = m_mie;
    chk_on    = 1'b1;
    we = acc && (op != CSR_OP_NONE);
    case (op)
      CSR_OP_SET:   wword = wdata | rd;
      CSR_OP_CLEAR: wword = ~wdata & rd;
      default:      wword = wdata;
    endcase
    // last cycle's events land now, unless a write hits the counter
    for (int i = 0; i < N_PERF_COUNTERS; i++) begin
      if (we && (addr == CSR_PCCR_ALL || (addr[11:5] == 7'h3C && addr[4:0] == 5'(i)))) begin
        m_cnt[i] = wword;
      end else if (m_inc[i] && !(m_pcmr[PCMR_SAT_BIT] && m_cnt[i] == 32'hFFFF_FFFF)) begin
        m_cnt[i] = m_cnt[i] + 32'd1;
      end
    end
    // qualify with pcer/pcmr as they stand before this write
    m_inc   = event_hits(ev, m_idv_q) & m_pcer & {N_PERF_COUNTERS{m_pcmr[PCMR_EN_BIT]}};
    m_idv_q = ev.id_valid;
    old_mie  = m_mie;
    old_mpie = m_mpie;
    if (we) begin
      case (addr)
        CSR_MSTATUS: begin
          m_mie  = wword[3];
          m_mpie = wword[7];
        end
        CSR_MEPC: m_mepc = wword;
        CSR_MCAUSE: begin
          m_irq  = wword[31];
          m_code = wword[4:0];
        end
        CSR_PCER: m_pcer = wword[N_PERF_COUNTERS-1:0];
        CSR_PCMR: m_pcmr = wword[1:0];
        default: ;
      endcase
    end
    // trap save beats mret and both beat the write
    if (tr.save_cause) begin
      m_mpie = old_mie;
      m_mie  = 1'b0;
      m_mepc = tr.save_if ? tr.pc_if : tr.pc_id;
      m_irq  = tr.cause[5];
      m_code = tr.cause[4:0];
    end else if (tr.restore_mret) begin
      m_mie  = old_mpie;
      m_mpie = 1'b1;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, 12'h0, CSR_OP_NONE, 32'h0, '0, '0);
  endtask

  task automatic read_csr(input logic [11:0] addr);
    drive_cycle(1'b1, addr, CSR_OP_NONE, 32'h0, '0, '0);
  endtask

  task automatic write_csr(input logic [11:0] addr, input csr_op_e op, input logic [31:0] data);
    drive_cycle(1'b1, addr, op, data, '0, '0);
  endtask

  task automatic read_counters();
    for (int i = 0; i < N_PERF_COUNTERS; i++) read_csr(12'h780 + 12'(i));
  endtask

  task automatic random_events(input int n);
    repeat (n) drive_cycle(1'b0, 12'h0, CSR_OP_NONE, 32'h0, '0, rand_events());
  endtask

  // one cycle pulse for save from IF or ID or for mret
  task automatic trap_pulse(input logic from_if, input logic mret);
    trap_req_t   tr;
    logic [31:0] r;
    r               = next_rand();
    tr              = '0;
    tr.save_cause   = !mret;
    tr.save_if      = !mret && from_if;
    tr.save_id      = !mret && !from_if;
    tr.restore_mret = mret;
    tr.cause        = r[21:16];
    tr.pc_if        = next_rand() & 32'hFFFF_FFFC;
    tr.pc_id        = next_rand() & 32'hFFFF_FFFC;
    drive_cycle(1'b0, 12'h0, CSR_OP_NONE, 32'h0, tr, '0);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic finish_test();
    // one idle cycle so the last compare has run
    idle(1);
    if (errors == err_mark) begin
      n_pass++;
      $display("test %s: pass", test_name);
    end else begin
      n_fail++;
      $display("test %s: FAIL, %0d errors", test_name, errors - err_mark);
    end
  endtask

  ////////////////////
  // compare
  ////////////////////

  always @(posedge clk) begin
    if (exp_valid && csr_rdata_o !== exp_rdata) begin
      $display("Error %s csr_rdata_o: expected %08h, actual %08h",
               test_name, exp_rdata, csr_rdata_o);
      errors++;
    end
    if (chk_on && epc_o !== exp_epc) begin
      $display("Error %s epc_o: expected %08h, actual %08h", test_name, exp_epc, epc_o);
      errors++;
    end
    if (chk_on && m_irq_enable_o !== exp_mie) begin
      $display("Error %s m_irq_enable_o: expected %0b, actual %0b",
               test_name, exp_mie, m_irq_enable_o);
      errors++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin
    logic [31:0] r;
    logic [11:0] addr;
    csr_op_e     op;
    lcg_state    = 32'h1f2e;
    rst_n        = 1'b0;
    csr_access_i = 1'b0;
    csr_addr_i   = '0;
    csr_op_i     = CSR_OP_NONE;
    csr_wdata_i  = 32'h0;
    trap_i       = '0;
    events_i     = '0;
    // model reset state
    m_mie   = 1'b0;
    m_mpie  = 1'b0;
    m_irq   = 1'b0;
    m_code  = 5'h0;
    m_mepc  = 32'h0;
    m_pcer  = '0;
    m_pcmr  = 2'b11;
    m_inc   = '0;
    m_idv_q = 1'b0;
    for (int i = 0; i < N_PERF_COUNTERS; i++) m_cnt[i] = 32'h0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    start_test("reset_values");
    read_csr(CSR_MSTATUS);
    read_csr(CSR_PCMR);
    read_csr(CSR_PCER);
    read_csr(12'h780);
    finish_test();

    start_test("csr_operations");
    repeat (20) begin
      r = next_rand();
      case (r[9:8])
        2'd0:    addr = CSR_MSTATUS;
        2'd1:    addr = CSR_MEPC;
        2'd2:    addr = CSR_MCAUSE;
        default: addr = CSR_PCER;
      endcase
      op = (r[13:12] == 2'b00) ? CSR_OP_WRITE : csr_op_e'(r[13:12]);
      write_csr(addr, op, next_rand());
      read_csr(addr);
    end
    finish_test();

    start_test("trap_save_mret");
    write_csr(CSR_MSTATUS, CSR_OP_WRITE, 32'h8);
    trap_pulse(1'b1, 1'b0);
    read_csr(CSR_MEPC);
    read_csr(CSR_MCAUSE);
    read_csr(CSR_MSTATUS);
    trap_pulse(1'b0, 1'b1);
    read_csr(CSR_MSTATUS);
    // mie and mpie both clear so mret must restore 0 and set mpie
    write_csr(CSR_MSTATUS, CSR_OP_WRITE, 32'h0);
    trap_pulse(1'b0, 1'b0);
    read_csr(CSR_MEPC);
    read_csr(CSR_MCAUSE);
    read_csr(CSR_MSTATUS);
    trap_pulse(1'b0, 1'b1);
    read_csr(CSR_MSTATUS);
    finish_test();

    start_test("event_counting");
    write_csr(CSR_PCCR_ALL, CSR_OP_WRITE, 32'h0);
    write_csr(CSR_PCER, CSR_OP_WRITE, next_rand() & 32'h7FF);
    random_events(200);
    write_csr(CSR_PCER, CSR_OP_WRITE, 32'h0);
    idle(4);
    read_counters();
    finish_test();

    start_test("saturation");
    write_csr(CSR_PCER, CSR_OP_WRITE, 32'h1);
    write_csr(12'h780, CSR_OP_WRITE, 32'hFFFF_FFF0);
    idle(40);
    read_csr(12'h780);
    // counter wraps once saturation is off
    write_csr(CSR_PCMR, CSR_OP_WRITE, 32'h1);
    idle(40);
    read_csr(12'h780);
    finish_test();

    start_test("enable_write_all");
    write_csr(CSR_PCER, CSR_OP_WRITE, 32'h7FF);
    write_csr(CSR_PCMR, CSR_OP_WRITE, 32'h0);
    random_events(20);
    read_counters();
    write_csr(CSR_PCCR_ALL, CSR_OP_SET, next_rand());
    read_csr(CSR_PCCR_ALL);
    read_counters();
    write_csr(CSR_PCCR_ALL, CSR_OP_CLEAR, next_rand());
    read_counters();
    write_csr(CSR_PCMR, CSR_OP_WRITE, 32'h3);
    finish_test();

    $display("tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
csr_pkg.sv
perf_pkg.sv
csr_access.sv
trap_ctrl.sv
perf_event_stage.sv
perf_counter_bank.sv
csr_unit.sv
csr_unit_asserts.sv
tb_csr_unit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_csr_unit
FILELIST  = list.f
OBJDIR    = obj_dir
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
